// ==== mem_bus_pkg.sv ====
// memory read port definitions
`default_nettype none

package mem_bus_pkg;

  localparam int unsigned AddrWidth    = 32; // byte address
  localparam int unsigned MemDataWidth = 64; // one stream word plus a spare word

  typedef logic [AddrWidth-1:0] addr_t;

  // streamer to memory
  typedef struct packed {
    logic  req;     // read request
    addr_t add;     // word-aligned byte address
    logic  r_ready; // consumer can take a response
  } mem_req_t;

  // memory to streamer, byte n of r_data sits at add + n
  typedef struct packed {
    logic                    gnt;     // request accepted
    logic                    r_valid; // response data present
    logic [MemDataWidth-1:0] r_data;  // little-endian read word
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== streamer_pkg.sv ====
// biased source streamer definitions
`default_nettype none

package streamer_pkg;

  localparam int unsigned StreamWidth   = 32; // output word
  localparam int unsigned CntWidth      = 16; // beat and length counters
  localparam int unsigned OffWidth      = 2;  // byte inside a 4-byte word
  localparam int unsigned AddrFifoDepth = 2;
  localparam int unsigned OffFifoDepth  = 8;  // >= grants outstanding before pop

  typedef logic [OffWidth-1:0] offset_t;

  // control plane, held stable while the streamer works
  typedef struct packed {
    logic                 req_start;
    logic                 ignore_bias; // skip bias handshake and add
    mem_bus_pkg::addr_t   base_addr;
    logic [CntWidth-1:0]  tot_len;     // total beats
    logic [CntWidth-1:0]  d0_len;      // inner dimension length
    mem_bus_pkg::addr_t   d0_stride;   // inner step in bytes
    mem_bus_pkg::addr_t   d1_stride;   // outer step in bytes
  } src_ctrl_t;

  typedef struct packed {
    logic ready_start; // high in every idle cycle
    logic done;        // one-cycle pulse at the end
  } src_flags_t;

  typedef struct packed {
    logic               valid;
    mem_bus_pkg::addr_t data; // added to base_addr
  } bias_t;

  typedef struct packed {
    logic                   valid;
    logic [StreamWidth-1:0] data;
  } stream_t;

  typedef enum logic [1:0] {
    idle,
    working,
    draining
  } src_state_e;

endpackage

`default_nettype wire

// ==== stream_fifo.sv ====
// synchronous valid/ready FIFO
`default_nettype none

module stream_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned Depth  = 2
) (
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wire        push_valid_i,
  input  wire item_t push_data_i,
  output logic       push_ready_o,
  output logic       pop_valid_o,
  output item_t      pop_data_o,
  input  wire        pop_ready_i,
  output logic       empty_o
);

  item_t                     mem_q [Depth]; // storage, no reset
  logic [$clog2(Depth)-1:0]  wr_ptr_q;
  logic [$clog2(Depth)-1:0]  rd_ptr_q;
  logic [$clog2(Depth):0]    cnt_q;       // fill level 0..Depth
  logic                      push;
  logic                      pop;

  assign push_ready_o = cnt_q != Depth;   // not full
  assign pop_valid_o  = cnt_q != '0;
  assign empty_o      = cnt_q == '0;
  assign pop_data_o   = mem_q[rd_ptr_q];  // head of queue

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1; // wrap at Depth
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  // a push refused while full must be offered again, else the item is lost
  push_retry_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_i && !push_ready_o |=> push_valid_i)
    else $error("stream_fifo: push dropped while full");

  // consumer must not pop from an empty queue
  pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ready_i |-> pop_valid_o)
    else $error("stream_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== strided_addr_gen.sv ====
// two-dimensional strided address generator
`default_nettype none

module strided_addr_gen (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire                               start_i,
  input  wire mem_bus_pkg::addr_t           base_i,
  input  wire [streamer_pkg::CntWidth-1:0]  tot_len_i,
  input  wire [streamer_pkg::CntWidth-1:0]  d0_len_i,
  input  wire mem_bus_pkg::addr_t           d0_stride_i,
  input  wire mem_bus_pkg::addr_t           d1_stride_i,
  output logic                              addr_valid_o,
  output mem_bus_pkg::addr_t                addr_o,
  input  wire                               addr_ready_i,
  output logic                              done_o
);

  mem_bus_pkg::addr_t                addr_q;      // current address
  mem_bus_pkg::addr_t                outer_q;     // start of current row
  mem_bus_pkg::addr_t                d0_stride_q;
  mem_bus_pkg::addr_t                d1_stride_q;
  logic [streamer_pkg::CntWidth-1:0] tot_len_q;
  logic [streamer_pkg::CntWidth-1:0] d0_len_q;
  logic [streamer_pkg::CntWidth-1:0] inner_q;     // index in row
  logic [streamer_pkg::CntWidth-1:0] count_q;     // addresses handed out
  logic                              active_q;
  logic                              done_q;
  logic                              accept;
  logic                              last;
  logic                              wrap;

  assign accept = active_q & addr_ready_i;
  assign last   = (count_q + 1'b1) == tot_len_q; // final address going out
  assign wrap   = (inner_q + 1'b1) == d0_len_q;  // end of inner dimension

  assign addr_valid_o = active_q;
  assign addr_o       = addr_q;
  assign done_o       = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      inner_q  <= '0;
      count_q  <= '0;
    end else if (start_i) begin
      active_q <= tot_len_i != '0;
      done_q   <= tot_len_i == '0; // empty job finishes at once
      inner_q  <= '0;
      count_q  <= '0;
    end else if (accept) begin
      count_q <= count_q + 1'b1;
      inner_q <= wrap ? '0 : inner_q + 1'b1;
      if (last) begin
        active_q <= 1'b0;
        done_q   <= 1'b1; // visible the cycle after last accept
      end
    end
  end

  // address datapath and sampled configuration
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q      <= base_i;
      outer_q     <= base_i;
      tot_len_q   <= tot_len_i;
      d0_len_q    <= d0_len_i;
      d0_stride_q <= d0_stride_i;
      d1_stride_q <= d1_stride_i;
    end else if (accept) begin
      if (wrap) begin
        outer_q <= outer_q + d1_stride_q; // next row
        addr_q  <= outer_q + d1_stride_q;
      end else begin
        addr_q  <= addr_q + d0_stride_q;
      end
    end
  end

  // offered address holds until taken
  addr_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_valid_o && !addr_ready_i |=> addr_valid_o && $stable(addr_o))
    else $error("strided_addr_gen: address withdrawn before accept");

endmodule

`default_nettype wire

// ==== source_realign.sv ====
// read response realignment onto the output stream
`default_nettype none

module source_realign (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire                         off_push_i,
  input  wire streamer_pkg::offset_t  off_i,
  input  wire mem_bus_pkg::mem_rsp_t  mem_rsp_i,
  input  wire                         stream_ready_i,
  output streamer_pkg::stream_t       stream_o
);

  logic                                hold_valid_q; // stalled beat waiting
  logic [mem_bus_pkg::MemDataWidth-1:0] hold_data_q;
  logic [mem_bus_pkg::MemDataWidth-1:0] raw_data;
  streamer_pkg::offset_t               off_head;
  logic                                off_valid;
  logic                                beat_out;

  // byte offsets of granted reads, in grant order
  stream_fifo #(
    .item_t ( streamer_pkg::offset_t     ),
    .Depth  ( streamer_pkg::OffFifoDepth )
  ) offset_fifo_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .push_valid_i ( off_push_i ),
    .push_data_i  ( off_i      ),
    .push_ready_o (            ),
    .pop_valid_o  ( off_valid  ),
    .pop_data_o   ( off_head   ),
    .pop_ready_i  ( beat_out   ),
    .empty_o      (            )
  );

  assign raw_data = mem_rsp_i.r_valid ? mem_rsp_i.r_data : hold_data_q; // live data wins
  assign stream_o.valid = mem_rsp_i.r_valid | hold_valid_q;
  // four bytes starting at the offset
  assign stream_o.data  = raw_data[{off_head, 3'b000} +: streamer_pkg::StreamWidth];
  assign beat_out = stream_o.valid & stream_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (mem_rsp_i.r_valid && !stream_ready_i) begin
      hold_valid_q <= 1'b1; // consumer stalled, park it
    end else if (stream_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.r_valid) hold_data_q <= mem_rsp_i.r_data;
  end

  // every response needs the offset pushed at its grant
  rsp_offset_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.r_valid |-> off_valid)
    else $error("source_realign: response without a pending offset");

  // parked beat must not be overrun by a new response
  hold_overrun_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_valid_q |-> !mem_rsp_i.r_valid)
    else $error("source_realign: response arrived over a held beat");

endmodule

`default_nettype wire

// ==== biased_source.sv ====
// biased source streamer top
`default_nettype none

module biased_source (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire streamer_pkg::src_ctrl_t ctrl_i,
  input  wire streamer_pkg::bias_t     bias_i,
  output logic                         bias_ready_o,
  output mem_bus_pkg::mem_req_t        mem_req_o,
  input  wire mem_bus_pkg::mem_rsp_t   mem_rsp_i,
  input  wire                          stream_ready_i,
  output streamer_pkg::stream_t        stream_o,
  output streamer_pkg::src_flags_t     flags_o
);

  streamer_pkg::src_state_e          state_q, state_d;
  logic                              start;        // start accepted this cycle
  mem_bus_pkg::addr_t                base_biased;
  logic                              gen_valid, gen_ready, gen_done;
  mem_bus_pkg::addr_t                gen_addr;
  logic                              fifo_valid, fifo_empty, grant;
  mem_bus_pkg::addr_t                fifo_addr;
  logic [streamer_pkg::CntWidth-1:0] beat_cnt_q, tot_len_q;
  logic                              cnt_clr;

  assign start = (state_q == streamer_pkg::idle) & ctrl_i.req_start &
                 (ctrl_i.ignore_bias | bias_i.valid);
  assign bias_ready_o = start & ~ctrl_i.ignore_bias; // consume bias only when used
  assign base_biased  = ctrl_i.ignore_bias ? ctrl_i.base_addr
                                           : ctrl_i.base_addr + bias_i.data;

  strided_addr_gen addr_gen_inst (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .start_i      ( start            ),
    .base_i       ( base_biased      ),
    .tot_len_i    ( ctrl_i.tot_len   ),
    .d0_len_i     ( ctrl_i.d0_len    ),
    .d0_stride_i  ( ctrl_i.d0_stride ),
    .d1_stride_i  ( ctrl_i.d1_stride ),
    .addr_valid_o ( gen_valid        ),
    .addr_o       ( gen_addr         ),
    .addr_ready_i ( gen_ready        ),
    .done_o       ( gen_done         )
  );

  stream_fifo #(
    .item_t ( mem_bus_pkg::addr_t         ),
    .Depth  ( streamer_pkg::AddrFifoDepth )
  ) addr_fifo_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .push_valid_i ( gen_valid  ),
    .push_data_i  ( gen_addr   ),
    .push_ready_o ( gen_ready  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_data_o   ( fifo_addr  ),
    .pop_ready_i  ( grant      ),
    .empty_o      ( fifo_empty )
  );

  // request only with room downstream, so one response at most is held
  assign mem_req_o.req     = (state_q != streamer_pkg::idle) & fifo_valid & stream_ready_i;
  assign mem_req_o.add     = (state_q != streamer_pkg::idle) ? {fifo_addr[31:2], 2'b00} : '0;
  assign mem_req_o.r_ready = stream_ready_i;
  assign grant = mem_req_o.req & mem_rsp_i.gnt; // pops the address

  source_realign realign_inst (
    .clk_i          ( clk_i                                     ),
    .rst_ni         ( rst_ni                                    ),
    .off_push_i     ( grant                                     ),
    .off_i          ( fifo_addr[streamer_pkg::OffWidth-1:0]     ),
    .mem_rsp_i      ( mem_rsp_i                                 ),
    .stream_ready_i ( stream_ready_i                            ),
    .stream_o       ( stream_o                                  )
  );

  always_comb begin
    state_d             = state_q;
    flags_o.ready_start = 1'b0;
    flags_o.done        = 1'b0;
    cnt_clr             = 1'b0;
    case (state_q)
      streamer_pkg::idle: begin
        flags_o.ready_start = 1'b1;
        if (start) state_d = streamer_pkg::working;
      end
      streamer_pkg::working: begin
        if (gen_done) state_d = streamer_pkg::draining; // all addresses produced
      end
      streamer_pkg::draining: begin
        if (fifo_empty && beat_cnt_q == tot_len_q) begin
          state_d      = streamer_pkg::idle;
          flags_o.done = 1'b1;
          cnt_clr      = 1'b1;
        end
      end
      default: state_d = streamer_pkg::idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= streamer_pkg::idle;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_clr) beat_cnt_q <= '0;
      else if (stream_o.valid && stream_ready_i) beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) tot_len_q <= ctrl_i.tot_len; // job length for drain check
  end

  // no extra beat left on the stream at done
  done_drain_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_o.done |-> !stream_o.valid)
    else $error("biased_source: done with a beat pending");

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// testbench read memory
`default_nettype none

module tb_mem_model (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        gnt_en_i,   // random stall from the testbench
  input  wire mem_bus_pkg::mem_req_t mem_req_i,
  output mem_bus_pkg::mem_rsp_t      mem_rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        rsp_valid_q;
  logic [63:0] rsp_data_q;
  logic        gnt;

  // byte at address a is the low 8 bits of a * 7 + 3
  function automatic logic [7:0] mem_byte(input mem_bus_pkg::addr_t a);
    logic [31:0] prod;
    prod = a * 32'd7 + 32'd3;
    return prod[7:0];
  endfunction

  function automatic logic [63:0] read_word(input mem_bus_pkg::addr_t a);
    logic [63:0] w;
    for (int n = 0; n < 8; n++) begin
      w[8*n +: 8] = mem_byte(a + n); // little-endian
    end
    return w;
  endfunction

  assign gnt                = mem_req_i.req & gnt_en_i;
  assign mem_rsp_o.gnt      = gnt;
  assign mem_rsp_o.r_valid  = rsp_valid_q; // fixed one-cycle latency
  assign mem_rsp_o.r_data   = rsp_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rsp_valid_q <= 1'b0;
    else         rsp_valid_q <= gnt;
  end

  always_ff @(posedge clk_i) begin
    if (gnt) rsp_data_q <= read_word(mem_req_i.add);
  end

endmodule

`default_nettype wire

// ==== tb_biased_source.sv ====
// biased source streamer testbench
`default_nettype none

module tb_biased_source;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTests = 9;

  typedef struct packed {
    mem_bus_pkg::addr_t                base_addr;
    mem_bus_pkg::addr_t                bias;
    logic                              ignore_bias;
    logic [streamer_pkg::CntWidth-1:0] tot_len;
    logic [streamer_pkg::CntWidth-1:0] d0_len;
    mem_bus_pkg::addr_t                d0_stride;
    mem_bus_pkg::addr_t                d1_stride;
    logic                              backpressure; // random ready and grant
  } test_row_t;

  // base, bias, ignore, tot_len, d0_len, d0_stride, d1_stride, backpressure
  test_row_t test_table [NumTests] = '{
    '{32'h0000_0100, 32'h0, 1'b1, 16'd8, 16'd8, 32'd4, 32'd0,   1'b0}, // aligned linear
    '{32'h0000_0201, 32'h0, 1'b1, 16'd5, 16'd5, 32'd4, 32'd0,   1'b0}, // offset 1
    '{32'h0000_0302, 32'h0, 1'b1, 16'd5, 16'd5, 32'd4, 32'd0,   1'b0}, // offset 2
    '{32'h0000_0403, 32'h0, 1'b1, 16'd5, 16'd5, 32'd4, 32'd0,   1'b0}, // offset 3
    '{32'h0000_1000, 32'h0, 1'b1, 16'd9, 16'd3, 32'd8, 32'd64,  1'b0}, // 2d pattern
    '{32'h0000_0500, 32'h23, 1'b0, 16'd6, 16'd6, 32'd4, 32'd0,  1'b0}, // bias added
    '{32'h0000_0600, 32'h40, 1'b1, 16'd4, 16'd4, 32'd4, 32'd0,  1'b0}, // bias ignored
    '{32'h0000_2002, 32'h11, 1'b0, 16'd20, 16'd4, 32'd12, 32'h94, 1'b1},
    '{32'h0000_3001, 32'h0, 1'b1, 16'd16, 16'd5, 32'd5, 32'd33, 1'b1}
  };

  logic                     clk;
  logic                     rst_n;
  streamer_pkg::src_ctrl_t  ctrl;
  streamer_pkg::bias_t      bias;
  logic                     bias_ready;
  mem_bus_pkg::mem_req_t    mem_req;
  mem_bus_pkg::mem_rsp_t    mem_rsp;
  logic                     stream_ready;
  streamer_pkg::stream_t    stream;
  streamer_pkg::src_flags_t flags;
  logic                     gnt_en;
  logic [31:0]              lfsr_q = 32'h6684;
  int                       cycle_cnt = 0;
  int                       cycle_limit;

  biased_source biased_source_inst (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .ctrl_i         ( ctrl         ),
    .bias_i         ( bias         ),
    .bias_ready_o   ( bias_ready   ),
    .mem_req_o      ( mem_req      ),
    .mem_rsp_i      ( mem_rsp      ),
    .stream_ready_i ( stream_ready ),
    .stream_o       ( stream       ),
    .flags_o        ( flags        )
  );

  tb_mem_model mem_model_inst (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .gnt_en_i  ( gnt_en  ),
    .mem_req_i ( mem_req ),
    .mem_rsp_o ( mem_rsp )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b      = lfsr_q[0];
  endtask

  function automatic logic [7:0] mem_byte(input mem_bus_pkg::addr_t a);
    logic [31:0] prod;
    prod = a * 32'd7 + 32'd3;
    return prod[7:0];
  endfunction

  function automatic logic [31:0] expected_word(input mem_bus_pkg::addr_t a);
    return {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};
  endfunction

  // beat k sits at row k / d0_len, column k % d0_len
  function automatic mem_bus_pkg::addr_t beat_addr(input test_row_t row, input int k);
    mem_bus_pkg::addr_t eff;
    eff = row.ignore_bias ? row.base_addr : row.base_addr + row.bias;
    return eff + (k / row.d0_len) * row.d1_stride + (k % row.d0_len) * row.d0_stride;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("%0t: %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic run_test(input test_row_t row);
    int   beats;
    bit   started;
    bit   finished;
    logic b0;
    logic b1;
    beats    = 0;
    started  = 1'b0;
    finished = 1'b0;
    @(negedge clk);
    ctrl.req_start   = 1'b1;
    ctrl.ignore_bias = row.ignore_bias;
    ctrl.base_addr   = row.base_addr;
    ctrl.tot_len     = row.tot_len;
    ctrl.d0_len      = row.d0_len;
    ctrl.d0_stride   = row.d0_stride;
    ctrl.d1_stride   = row.d1_stride;
    bias.valid       = 1'b1; // offered even when ignored
    bias.data        = row.bias;
    while (!finished) begin
      if (row.backpressure) begin
        draw_bit(b0);
        draw_bit(b1);
        stream_ready = b0 | b1; // ready 3 of 4 cycles
        draw_bit(b0);
        draw_bit(b1);
        gnt_en = b0 | b1;
      end else begin
        stream_ready = 1'b1;
        gnt_en       = 1'b1;
      end
      #2; // outputs settled, edge still ahead
      if (!started && flags.ready_start) begin
        check_value("bias_ready_o", bias_ready, !row.ignore_bias); // start accepted here
        started = 1'b1;
      end else begin
        check_value("bias_ready_o", bias_ready, 1'b0);
      end
      if (stream.valid && stream_ready) begin
        if (beats >= row.tot_len) fail_run("stream delivered more beats than tot_len");
        check_value("stream_o.data", stream.data, expected_word(beat_addr(row, beats)));
        beats++;
      end
      if (flags.done) begin
        check_value("beat count at done", beats, row.tot_len);
        finished = 1'b1;
      end
      @(negedge clk);
      ctrl.req_start = 1'b0;
      bias.valid     = 1'b0;
    end
    stream_ready = 1'b1;
    #2;
    check_value("flags_o.done", flags.done, 1'b0); // single-cycle pulse
    check_value("flags_o.ready_start", flags.ready_start, 1'b1);
    check_value("stream_o.valid", stream.valid, 1'b0); // nothing after done
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("simulation ran past %0d cycles without finishing", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    cycle_limit  = 40;
    for (int i = 0; i < NumTests; i++) cycle_limit += 8 * test_table[i].tot_len;
    rst_n        = 1'b0;
    ctrl         = '0;
    bias         = '0;
    stream_ready = 1'b0;
    gnt_en       = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    #2;
    check_value("flags_o.ready_start", flags.ready_start, 1'b1);
    check_value("flags_o.done", flags.done, 1'b0);
    check_value("mem_req_o.req", mem_req.req, 1'b0);
    check_value("stream_o.valid", stream.valid, 1'b0);
    check_value("bias_ready_o", bias_ready, 1'b0);
    for (int i = 0; i < NumTests; i++) begin
      run_test(test_table[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
mem_bus_pkg.sv
streamer_pkg.sv
stream_fifo.sv
strided_addr_gen.sv
source_realign.sv
biased_source.sv
tb_mem_model.sv
tb_biased_source.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_biased_source \
  && ./obj_dir/Vtb_biased_source \
  || { echo "simulation did not pass"; exit 1; }
